// File: list.f
rtl/axi_trn_pkg.sv
rtl/trn_tx_format.sv
rtl/tx_prev_pipeline.sv
rtl/tx_link_ctrl.sv
rtl/axi_trn_tx_bridge.sv
bench/axi_trn_tx_props.sv
bench/tb_axi_trn_tx_bridge.sv

// File: Bender.yml
package:
  name: axi_trn_tx_bridge

sources:
  - files:
      - rtl/axi_trn_pkg.sv
      - rtl/trn_tx_format.sv
      - rtl/tx_prev_pipeline.sv
      - rtl/tx_link_ctrl.sv
      - rtl/axi_trn_tx_bridge.sv
  - target: test
    files:
      - bench/axi_trn_tx_props.sv
      - bench/tb_axi_trn_tx_bridge.sv

// File: bench/tb_axi_trn_tx_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_trn_tx_bridge;

  import axi_trn_pkg::*;

  localparam int num_pkts = 300;

  // One expected TRN beat
  typedef struct packed {
    logic [15:0] pkt;
    logic [7:0]  idx;
    tdata_t      data;
    tstrb_t      strb;
    logic        last;
    tuser_t      user;
  } exp_beat_t;

  logic   com_iclk;
  logic   com_sysrst;
  tdata_t s_axis_tx_tdata;
  logic   s_axis_tx_tvalid;
  logic   s_axis_tx_tlast;
  tstrb_t s_axis_tx_tstrb;
  tuser_t s_axis_tx_tuser;
  logic   s_axis_tx_tready;
  tdata_t trn_td;
  logic   trn_tsof;
  logic   trn_teof;
  logic   trn_tsrc_rdy;
  logic   trn_tsrc_dsc;
  logic   trn_terrfwd;
  logic   trn_tstr;
  logic   trn_tecrc_gen;
  trem_t  trn_trem;
  logic   trn_tdst_rdy;
  logic   trn_lnk_up;

  // Stimulus state
  int          pkt_len [num_pkts];
  int          total_beats;
  logic [31:0] rng;
  logic [15:0] pkt_num;
  logic [7:0]  beat_idx;
  int          down_cnt;
  logic        axi_acc;

  // Scoreboard model
  exp_beat_t   exp_q [$];
  logic        m_in_pkt;
  logic        m_flush;
  int          flush_cnt;
  logic        m_resync;
  logic [15:0] min_pkt;

  axi_trn_tx_bridge i_dut (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .s_axis_tx_tdata  (s_axis_tx_tdata),
    .s_axis_tx_tvalid (s_axis_tx_tvalid),
    .s_axis_tx_tlast  (s_axis_tx_tlast),
    .s_axis_tx_tstrb  (s_axis_tx_tstrb),
    .s_axis_tx_tuser  (s_axis_tx_tuser),
    .s_axis_tx_tready (s_axis_tx_tready),
    .trn_td           (trn_td),
    .trn_tsof         (trn_tsof),
    .trn_teof         (trn_teof),
    .trn_tsrc_rdy     (trn_tsrc_rdy),
    .trn_tsrc_dsc     (trn_tsrc_dsc),
    .trn_terrfwd      (trn_terrfwd),
    .trn_tstr         (trn_tstr),
    .trn_tecrc_gen    (trn_tecrc_gen),
    .trn_trem         (trn_trem),
    .trn_tdst_rdy     (trn_tdst_rdy),
    .trn_lnk_up       (trn_lnk_up)
  );

  bind axi_trn_tx_bridge axi_trn_tx_props i_props (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .s_axis_tx_tready (s_axis_tx_tready),
    .trn_tsrc_rdy     (trn_tsrc_rdy),
    .trn_tdst_rdy     (trn_tdst_rdy),
    .trn_lnk_up       (trn_lnk_up)
  );

  initial begin
    com_iclk = 1'b0;
    forever #5 com_iclk = ~com_iclk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_data(input string name, input tdata_t got, input tdata_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
                              $time, name, got, exp));
    end
  endtask

  task automatic compare_rem(input string name, input trem_t got, input trem_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
                              $time, name, got, exp));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
                              $time, name, got, exp));
    end
  endtask

  // ------------------------------
  // Source, sink and link stimulus
  // ------------------------------

  // Data tags each beat with a marker, packet number, beat index and random low dword
  task automatic present_beat();
    logic [31:0] r;
    logic        last;
    r = next_rand();
    last = (beat_idx == pkt_len[pkt_num] - 1);
    s_axis_tx_tdata  = {8'ha5, pkt_num, beat_idx, next_rand()};
    s_axis_tx_tlast  = last;
    // Short last beat keeps only the low dword
    s_axis_tx_tstrb  = (last && r[0]) ? 8'h0f : 8'hff;
    s_axis_tx_tuser  = r[7:4];
    s_axis_tx_tvalid = 1'b1;
  endtask

  task automatic run_stimulus();
    logic [31:0] r;
    while (pkt_num < num_pkts) begin
      @(negedge com_iclk);
      r = next_rand();
      trn_tdst_rdy = (r[1:0] != 2'd0);
      // Rare link drops of 3 to 10 cycles away from both ends of the run
      if (down_cnt == 0 && r[14:8] == 7'd0 && pkt_num > 4 && pkt_num < num_pkts - 5) begin
        down_cnt = 3 + r[18:16];
      end
      trn_lnk_up = (down_cnt == 0);
      if (down_cnt > 0) begin
        down_cnt--;
      end
      // Advance past the beat taken on the last rising edge
      if (axi_acc) begin
        if (s_axis_tx_tlast) begin
          pkt_num++;
          beat_idx = 8'd0;
        end else begin
          beat_idx++;
        end
        s_axis_tx_tvalid = 1'b0;
      end
      if (!s_axis_tx_tvalid && pkt_num < num_pkts && r[3:2] != 2'd0) begin
        present_beat();
      end
    end
  endtask

  // ------------------------------
  // Scoreboard
  // ------------------------------

  task automatic record_beat();
    exp_beat_t e;
    e.pkt  = s_axis_tx_tdata[55:40];
    e.idx  = s_axis_tx_tdata[39:32];
    e.data = s_axis_tx_tdata;
    e.strb = s_axis_tx_tstrb;
    e.last = s_axis_tx_tlast;
    e.user = s_axis_tx_tuser;
    // First packet after a link drop retires whatever the drop cut off
    if (m_resync && e.idx == 8'd0) begin
      while (exp_q.size() != 0 && exp_q[0].pkt < e.pkt) begin
        void'(exp_q.pop_front());
      end
      min_pkt  = e.pkt;
      m_resync = 1'b0;
    end
    exp_q.push_back(e);
  endtask

  task automatic check_transfer();
    exp_beat_t   e;
    logic [15:0] got_pkt;
    // Packet number now sits in the TRN low half
    got_pkt = trn_td[23:8];
    if (got_pkt >= min_pkt) begin
      if (exp_q.size() == 0) begin
        stop_on_error($sformatf("TRN transfer at %0t with no AXI beat waiting for it", $time));
      end else begin
        e = exp_q.pop_front();
        compare_data("trn_td", trn_td, {e.data[31:0], e.data[63:32]});
        compare_flag("trn_tsof", trn_tsof, e.idx == 8'd0);
        compare_flag("trn_teof", trn_teof, e.last);
        compare_rem("trn_trem", trn_trem, trem_t'(e.strb[strb_w-1]));
        compare_flag("trn_tecrc_gen", trn_tecrc_gen, e.user[user_ecrc_bit]);
        compare_flag("trn_terrfwd", trn_terrfwd, e.user[user_errfwd_bit]);
        compare_flag("trn_tstr", trn_tstr, e.user[user_str_bit]);
        compare_flag("trn_tsrc_dsc", trn_tsrc_dsc, e.user[user_dsc_bit]);
      end
    end
  endtask

  // Values read here are the ones before this edge updates the DUT
  always @(posedge com_iclk) begin
    axi_acc = s_axis_tx_tvalid && s_axis_tx_tready;
    if (!com_sysrst) begin
      if (i_dut.i_props.err_count != 0) begin
        stop_on_error("a bound assertion on the handshake or link rules failed");
      end
      // Draining a cut packet runs at full rate
      if (m_flush && flush_cnt >= 1) begin
        compare_flag("s_axis_tx_tready", s_axis_tx_tready, 1'b1);
      end
      if (trn_tsrc_rdy && trn_tdst_rdy) begin
        check_transfer();
      end
      if (axi_acc && trn_lnk_up && !m_flush) begin
        record_beat();
      end
      // Link drop inside a packet flushes up to its last beat
      if (m_in_pkt && !trn_lnk_up && !(axi_acc && s_axis_tx_tlast)) begin
        flush_cnt = m_flush ? flush_cnt + 1 : 0;
        m_flush   = 1'b1;
      end else if (axi_acc && s_axis_tx_tlast) begin
        m_flush = 1'b0;
      end else if (m_flush) begin
        flush_cnt++;
      end
      if (axi_acc) begin
        m_in_pkt = !s_axis_tx_tlast;
      end
      if (!trn_lnk_up) begin
        m_resync = 1'b1;
      end
    end
  end

  // ------------------------------
  // Watchdog
  // ------------------------------

  initial begin
    wait (total_beats > 0);
    repeat (total_beats * 40) @(posedge com_iclk);
    stop_on_error("timeout, the bridge stopped moving beats before the run ended");
  end

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    logic [31:0] r;
    rng         = 32'h0dbf3a0a;
    total_beats = 0;
    for (int i = 0; i < num_pkts; i++) begin
      r = next_rand();
      pkt_len[i] = 1 + int'(r % 6);
      total_beats += pkt_len[i];
    end
    com_sysrst       = 1'b1;
    s_axis_tx_tdata  = '0;
    s_axis_tx_tvalid = 1'b0;
    s_axis_tx_tlast  = 1'b0;
    s_axis_tx_tstrb  = '0;
    s_axis_tx_tuser  = '0;
    trn_tdst_rdy     = 1'b0;
    trn_lnk_up       = 1'b1;
    pkt_num   = '0;
    beat_idx  = '0;
    down_cnt  = 0;
    axi_acc   = 1'b0;
    m_in_pkt  = 1'b0;
    m_flush   = 1'b0;
    flush_cnt = 0;
    m_resync  = 1'b0;
    min_pkt   = '0;
    repeat (2) @(posedge com_iclk);
    @(negedge com_iclk);
    com_sysrst = 1'b0;
    run_stimulus();
    // Let the sink drain what is left
    trn_lnk_up   = 1'b1;
    trn_tdst_rdy = 1'b1;
    while (exp_q.size() != 0) begin
      @(negedge com_iclk);
    end
    repeat (8) @(negedge com_iclk);
    // Drained bridge offers nothing and accepts again
    if (!trn_tsrc_rdy && s_axis_tx_tready) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_on_error("bridge still busy after the scoreboard drained");
    end
  end

endmodule

`default_nettype wire

// File: bench/axi_trn_tx_props.sv
`timescale 1ns/1ps
`default_nettype none

module axi_trn_tx_props (
  input logic com_iclk,
  input logic com_sysrst,
  input logic s_axis_tx_tready,
  input logic trn_tsrc_rdy,
  input logic trn_tdst_rdy,
  input logic trn_lnk_up
);

  // Number of failed assertions
  int unsigned err_count = 0;

  // ------------------------------
  // Reset and link rules
  // ------------------------------

  // Both ready outputs come out of reset low
  a_ready_low_after_reset : assert property (
    @(posedge com_iclk) com_sysrst |=> (!s_axis_tx_tready && !trn_tsrc_rdy)
  ) else begin
    $error("ready output high on the first edge after reset");
    err_count++;
  end

  // TRN side is disabled one edge after the link drops
  a_no_transfer_link_down : assert property (
    @(posedge com_iclk) disable iff (com_sysrst)
    !trn_lnk_up |=> !(trn_tsrc_rdy && trn_tdst_rdy)
  ) else begin
    $error("TRN transfer while the link is down");
    err_count++;
  end

  // An offered beat stays offered while the sink throttles
  a_src_rdy_held : assert property (
    @(posedge com_iclk) disable iff (com_sysrst)
    (trn_tsrc_rdy && !trn_tdst_rdy && trn_lnk_up) |=> trn_tsrc_rdy
  ) else begin
    $error("trn_tsrc_rdy dropped while the sink was throttling");
    err_count++;
  end

endmodule

`default_nettype wire

// File: rtl/axi_trn_tx_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_trn_tx_bridge (
  input  logic                com_iclk,
  input  logic                com_sysrst,
  // AXI-Stream transmit input
  input  axi_trn_pkg::tdata_t s_axis_tx_tdata,
  input  logic                s_axis_tx_tvalid,
  input  logic                s_axis_tx_tlast,
  input  axi_trn_pkg::tstrb_t s_axis_tx_tstrb,
  input  axi_trn_pkg::tuser_t s_axis_tx_tuser,
  output logic                s_axis_tx_tready,
  // TRN transmit output
  output axi_trn_pkg::tdata_t trn_td,
  output logic                trn_tsof,
  output logic                trn_teof,
  output logic                trn_tsrc_rdy,
  output logic                trn_tsrc_dsc,
  output logic                trn_terrfwd,
  output logic                trn_tstr,
  output logic                trn_tecrc_gen,
  output axi_trn_pkg::trem_t  trn_trem,
  input  logic                trn_tdst_rdy,
  input  logic                trn_lnk_up
);

  import axi_trn_pkg::*;

  // Registered beat between pipeline and format stage
  tdata_t reg_tdata;
  logic   reg_tvalid;
  tstrb_t reg_tstrb;
  logic   reg_tlast;
  tuser_t reg_tuser;

  // Link control back to the pipeline
  logic   trn_disable;

  // ------------------------------
  // Input register stage
  // ------------------------------

  tx_prev_pipeline i_pipeline (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .s_axis_tx_tdata  (s_axis_tx_tdata),
    .s_axis_tx_tvalid (s_axis_tx_tvalid),
    .s_axis_tx_tstrb  (s_axis_tx_tstrb),
    .s_axis_tx_tlast  (s_axis_tx_tlast),
    .s_axis_tx_tuser  (s_axis_tx_tuser),
    .tready           (s_axis_tx_tready),
    .trn_tdst_rdy     (trn_tdst_rdy),
    .trn_disable      (trn_disable),
    .reg_tdata        (reg_tdata),
    .reg_tvalid       (reg_tvalid),
    .reg_tstrb        (reg_tstrb),
    .reg_tlast        (reg_tlast),
    .reg_tuser        (reg_tuser),
    .trn_tsrc_rdy     (trn_tsrc_rdy)
  );

  // Link and flush handling that owns tready
  tx_link_ctrl i_link_ctrl (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .s_axis_tx_tvalid (s_axis_tx_tvalid),
    .s_axis_tx_tlast  (s_axis_tx_tlast),
    .trn_tsrc_rdy     (trn_tsrc_rdy),
    .trn_tdst_rdy     (trn_tdst_rdy),
    .trn_lnk_up       (trn_lnk_up),
    .tready           (s_axis_tx_tready),
    .trn_disable      (trn_disable)
  );

  // TRN format of the registered beat
  trn_tx_format i_format (
    .com_iclk      (com_iclk),
    .com_sysrst    (com_sysrst),
    .reg_tdata     (reg_tdata),
    .reg_tvalid    (reg_tvalid),
    .reg_tstrb     (reg_tstrb),
    .reg_tlast     (reg_tlast),
    .reg_tuser     (reg_tuser),
    .trn_tsrc_rdy  (trn_tsrc_rdy),
    .trn_tdst_rdy  (trn_tdst_rdy),
    .trn_lnk_up    (trn_lnk_up),
    .trn_td        (trn_td),
    .trn_tsof      (trn_tsof),
    .trn_teof      (trn_teof),
    .trn_trem      (trn_trem),
    .trn_tsrc_dsc  (trn_tsrc_dsc),
    .trn_terrfwd   (trn_terrfwd),
    .trn_tstr      (trn_tstr),
    .trn_tecrc_gen (trn_tecrc_gen)
  );

endmodule

`default_nettype wire

// File: rtl/tx_link_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tx_link_ctrl (
  input  logic com_iclk,
  input  logic com_sysrst,
  // AXI source side
  input  logic s_axis_tx_tvalid,
  input  logic s_axis_tx_tlast,
  // TRN handshake and link state
  input  logic trn_tsrc_rdy,
  input  logic trn_tdst_rdy,
  input  logic trn_lnk_up,
  // Registered AXI ready
  output logic tready,
  // Blocks trn_tsrc_rdy while high
  output logic trn_disable
);

  // Accepted AXI beat, and the one that ends a packet
  logic axi_beat_live;
  logic axi_end_packet;

  // AXI side is between a first and a last beat
  logic axi_in_packet;

  // Draining a packet cut by a link drop
  logic flush_axi;

  assign axi_beat_live  = s_axis_tx_tvalid && tready;
  assign axi_end_packet = axi_beat_live && s_axis_tx_tlast;

  // ------------------------------
  // AXI packet tracking
  // ------------------------------

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      axi_in_packet <= 1'b0;
    end else if (axi_beat_live) begin
      // Open on any non-last beat, close on the last one
      axi_in_packet <= !s_axis_tx_tlast;
    end
  end

  // ------------------------------
  // Flush on link drop
  // ------------------------------

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      flush_axi <= 1'b0;
    end else if (axi_in_packet && !trn_lnk_up && !axi_end_packet) begin
      // Packet cut in half; swallow the rest of it
      flush_axi <= 1'b1;
    end else if (axi_end_packet) begin
      flush_axi <= 1'b0;
    end
  end

  // ------------------------------
  // tready generation
  // ------------------------------

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      tready <= 1'b0;
    end else if (flush_axi && !axi_end_packet) begin
      // Drain the cut packet at full rate
      tready <= 1'b1;
    end else if (trn_lnk_up) begin
      // Follow the sink while busy
      // Idle TRN side keeps the pipeline primed
      tready <= trn_tdst_rdy || !trn_tsrc_rdy;
    end else begin
      // Link down and nothing to drain
      tready <= 1'b0;
    end
  end

  // ------------------------------
  // TRN disable
  // ------------------------------

  // Set from a link drop until AXI is ready again with no flush, which
  // leaves the previous-value buffer refilled before TRN restarts
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      trn_disable <= 1'b1;
    end else if (!trn_lnk_up) begin
      trn_disable <= 1'b1;
    end else if (!flush_axi && tready) begin
      trn_disable <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/tx_prev_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tx_prev_pipeline (
  input  logic                com_iclk,
  input  logic                com_sysrst,
  // AXI-Stream beat from the source
  input  axi_trn_pkg::tdata_t s_axis_tx_tdata,
  input  logic                s_axis_tx_tvalid,
  input  axi_trn_pkg::tstrb_t s_axis_tx_tstrb,
  input  logic                s_axis_tx_tlast,
  input  axi_trn_pkg::tuser_t s_axis_tx_tuser,
  // Registered tready from the link control
  input  logic                tready,
  input  logic                trn_tdst_rdy,
  input  logic                trn_disable,
  // Registered beat towards the format stage
  output axi_trn_pkg::tdata_t reg_tdata,
  output logic                reg_tvalid,
  output axi_trn_pkg::tstrb_t reg_tstrb,
  output logic                reg_tlast,
  output axi_trn_pkg::tuser_t reg_tuser,
  output logic                trn_tsrc_rdy
);

  import axi_trn_pkg::*;

  // Previous-value buffer
  tdata_t tdata_prev;
  logic   tvalid_prev;
  tstrb_t tstrb_prev;
  logic   tlast_prev;
  tuser_t tuser_prev;

  // Buffer selection flags
  logic data_hold;
  logic data_prev;

  // ------------------------------
  // Previous-value buffer
  // ------------------------------

  // tready is registered, so the sink's throttle reaches the source a
  // cycle late; the beat taken in that cycle is parked here
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      tvalid_prev <= 1'b0;
    end else if (tready) begin
      tvalid_prev <= s_axis_tx_tvalid;
    end
  end

  always_ff @(posedge com_iclk) begin
    if (tready) begin
      tdata_prev <= s_axis_tx_tdata;
      tstrb_prev <= s_axis_tx_tstrb;
      tlast_prev <= s_axis_tx_tlast;
      tuser_prev <= s_axis_tx_tuser;
    end
  end

  // ------------------------------
  // Hold / previous / current
  // ------------------------------

  // Hold while a TRN beat is offered and not taken
  assign data_hold = trn_tsrc_rdy && !trn_tdst_rdy;

  // Cycle after a hold replays the parked beat
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      data_prev <= 1'b0;
    end else begin
      data_prev <= data_hold;
    end
  end

  // Valid bit of the output register
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      reg_tvalid <= 1'b0;
    end else if (!data_hold) begin
      reg_tvalid <= data_prev ? tvalid_prev : s_axis_tx_tvalid;
    end
  end

  // Payload follows the same selection
  always_ff @(posedge com_iclk) begin
    if (!data_hold) begin
      if (data_prev) begin
        reg_tdata <= tdata_prev;
        reg_tstrb <= tstrb_prev;
        reg_tlast <= tlast_prev;
        reg_tuser <= tuser_prev;
      end else begin
        reg_tdata <= s_axis_tx_tdata;
        reg_tstrb <= s_axis_tx_tstrb;
        reg_tlast <= s_axis_tx_tlast;
        reg_tuser <= s_axis_tx_tuser;
      end
    end
  end

  // Offer a beat only while the TRN side is enabled
  assign trn_tsrc_rdy = reg_tvalid && !trn_disable;

endmodule

`default_nettype wire

// File: rtl/trn_tx_format.sv
`timescale 1ns/1ps
`default_nettype none

module trn_tx_format (
  input  logic                com_iclk,
  input  logic                com_sysrst,
  // Registered beat from the pipeline stage
  input  axi_trn_pkg::tdata_t reg_tdata,
  input  logic                reg_tvalid,
  input  axi_trn_pkg::tstrb_t reg_tstrb,
  input  logic                reg_tlast,
  input  axi_trn_pkg::tuser_t reg_tuser,
  // TRN handshake and link state
  input  logic                trn_tsrc_rdy,
  input  logic                trn_tdst_rdy,
  input  logic                trn_lnk_up,
  // TRN beat
  output axi_trn_pkg::tdata_t trn_td,
  output logic                trn_tsof,
  output logic                trn_teof,
  output axi_trn_pkg::trem_t  trn_trem,
  // TRN sideband
  output logic                trn_tsrc_dsc,
  output logic                trn_terrfwd,
  output logic                trn_tstr,
  output logic                trn_tecrc_gen
);

  import axi_trn_pkg::*;

  // High between a non-last sof transfer and the eof transfer
  logic trn_in_packet;

  // ------------------------------
  // Data path conversion
  // ------------------------------

  // Upper AXI dword goes to the TRN low half
  assign trn_td = {reg_tdata[data_w/2-1:0], reg_tdata[data_w-1:data_w/2]};

  // Strobe of byte 7 tells whether the upper dword is live
  assign trn_trem = reg_tstrb[strb_w-1];

  assign trn_teof = reg_tlast;

  // Sideband mapping
  assign trn_tecrc_gen = reg_tuser[user_ecrc_bit];
  assign trn_terrfwd   = reg_tuser[user_errfwd_bit];
  assign trn_tstr      = reg_tuser[user_str_bit];
  assign trn_tsrc_dsc  = reg_tuser[user_dsc_bit];

  // ------------------------------
  // Start of packet
  // ------------------------------

  // Any valid beat outside a packet opens one
  assign trn_tsof = reg_tvalid && !trn_in_packet;

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      trn_in_packet <= 1'b0;
    end else if (!trn_lnk_up) begin
      // Link loss abandons the packet on the TRN side
      trn_in_packet <= 1'b0;
    end else if (trn_tsrc_rdy && trn_tdst_rdy) begin
      // Only an accepted beat moves the packet state
      if (trn_teof) begin
        trn_in_packet <= 1'b0;
      end else if (trn_tsof) begin
        trn_in_packet <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_trn_pkg.sv
`default_nettype none

package axi_trn_pkg;

  // ------------------------------
  // Beat geometry
  // ------------------------------

  // One beat carries two dwords
  localparam int data_w = 64;

  // One strobe per data byte
  localparam int strb_w = data_w / 8;

  // Remainder flags a half-full last beat
  localparam int rem_w = 1;

  // AXI sideband bits carried in tuser
  localparam int user_w = 4;

  // ------------------------------
  // Vector types
  // ------------------------------

  typedef logic [data_w-1:0] tdata_t;
  typedef logic [strb_w-1:0] tstrb_t;
  typedef logic [user_w-1:0] tuser_t;
  typedef logic [rem_w-1:0]  trem_t;

  // ------------------------------
  // tuser bit positions
  // ------------------------------

  // ECRC generate request
  localparam int user_ecrc_bit   = 0;
  // Error forward poisons the TLP
  localparam int user_errfwd_bit = 1;
  // Streaming mode enable
  localparam int user_str_bit    = 2;
  // Source discontinue
  localparam int user_dsc_bit    = 3;

endpackage

`default_nettype wire
